//--- sbit_rx_settings.svh
`ifndef SBIT_RX_SETTINGS_SVH
`define SBIT_RX_SETTINGS_SVH

// --------------------
// lane layout
`define SBIT_RX_NUM_LANES       4     // s-bit lanes beside the sot lane

// --------------------
// phase voter
`define SBIT_RX_ERR_COUNT_W     8     // shift is voted once this counter is all ones
`define SBIT_RX_STABLE_COUNT_W  6     // locked once this counter is all ones

// --------------------
// apb register map
`define SBIT_RX_APB_ADDR_W      4
`define SBIT_RX_ADDR_CTRL       4'h0  // manual, manual_phase, manual_pos_edge
`define SBIT_RX_ADDR_STATUS     4'h4  // phase, pos edge, locked, err_seen
`define SBIT_RX_STS_ERR_BIT     4     // write 1 here to drop err_seen

`endif

//--- sbit_rx_pkg.sv
package sbit_rx_pkg;

  // split view of one oversample word
  typedef struct packed {
    logic [3:0] neg_half;  // falling half samples
    logic [3:0] pos_half;  // rising half samples, bit k belongs to phase k
  } os_halves_t;

  // one fastclock worth of oversamples, read flat or by half
  typedef union packed {
    logic [7:0] raw;       // time order, bit 0 is the earliest sample
    os_halves_t halves;
  } os_word_t;

  // sampling phase of the voter
  // the value k picks bit k of each half
  typedef enum logic [1:0] {
    PHASE_00 = 2'b00,
    PHASE_01 = 2'b01,
    PHASE_10 = 2'b10,
    PHASE_11 = 2'b11
  } phase_t;

endpackage

//--- sample_front.sv
`timescale 1ns/10ps

module sample_front (
  input  logic                  fastclock,
  input  logic                  rst_n,
  input  sbit_rx_pkg::os_word_t word,        // straight from the deserializer
  output sbit_rx_pkg::os_word_t word_clean,  // even bits put back to true polarity
  output logic [3:0]            eq4          // transition flags between phase k and k+1
);
  import sbit_rx_pkg::*;

  os_word_t   word_q;  // stage 1, inverted leg still mixed in
  logic [7:0] q;       // short alias for the raw bits
  logic       prev7;   // last sample of the previous word, true polarity

  assign q     = word_q.raw;
  assign prev7 = word_clean.raw[7];  // odd bit, never inverted

  // --------------------
  // stage 1
  always_ff @(posedge fastclock) begin
    word_q <= word;
  end

  // --------------------
  // stage 2
  // adjacent raw bits sit on opposite buffer legs
  // so a raw match means the real data flipped between those samples
  always_ff @(posedge fastclock) begin
    word_clean.raw <= q ^ 8'h55;  // undo the inverted leg
    if (!rst_n) begin
      eq4 <= '0;
    end else begin
      eq4[0] <= (q[0] == q[1]) || (q[4] == q[5]);  // phase 0 to 1
      eq4[1] <= (q[1] == q[2]) || (q[5] == q[6]);  // phase 1 to 2
      eq4[2] <= (q[2] == q[3]) || (q[6] == q[7]);  // phase 2 to 3
      // phase 3 to 0 wraps into the next half and into the next word
      eq4[3] <= (q[3] == q[4]) || (prev7 == q[0]);
    end
  end

endmodule

//--- phase_vote.sv
`timescale 1ns/10ps
`include "sbit_rx_settings.svh"

module phase_vote (
  input  logic                fastclock,
  input  logic                rst_n,
  input  logic [3:0]          eq4,           // transition flags from the sample front
  input  logic                phase_err,     // error seen at the current phase
  input  logic                manual,        // hold the machine on manual_phase
  input  sbit_rx_pkg::phase_t manual_phase,
  output sbit_rx_pkg::phase_t phase,
  output logic                locked
);
  import sbit_rx_pkg::*;

  logic [`SBIT_RX_ERR_COUNT_W-1:0]    err_count;
  logic [`SBIT_RX_STABLE_COUNT_W-1:0] stable_count;
  phase_t                             phase_last;  // for spotting a fresh move

  logic [1:0] ph_dn;     // one phase earlier
  logic [1:0] ph_up;     // one phase later
  logic [1:0] ph_opp;    // opposite phase
  logic       vote_to_shift;
  logic       link_stable;
  logic       move_dn;
  logic       move_up;
  logic       shift;

  assign ph_dn  = phase - 2'd1;
  assign ph_up  = phase + 2'd1;
  assign ph_opp = phase + 2'd2;

  assign vote_to_shift = &err_count;     // enough errors piled up
  assign link_stable   = &stable_count;  // long error-free run
  assign locked        = link_stable;

  // --------------------
  // direction of the move
  // edge just after the sample, step back
  assign move_dn = eq4[phase];
  // edge just before, or edge facing the sample from the far side, step ahead
  assign move_up = eq4[ph_dn] || eq4[ph_opp];
  // only move on a cycle that actually shows where the edge is
  assign shift   = vote_to_shift && (move_dn || move_up);

  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      phase        <= PHASE_00;
      phase_last   <= PHASE_00;
      err_count    <= '0;
      stable_count <= '0;
    end else if (manual) begin
      phase        <= manual_phase;  // software owns the phase
      phase_last   <= manual_phase;
      err_count    <= '0;
      stable_count <= '0;
    end else begin
      phase_last <= phase;

      // good cycles in a row, any error starts over
      if (phase_err) begin
        stable_count <= '0;
      end else if (!link_stable) begin
        stable_count <= stable_count + 1'b1;
      end

      // error votes, wiped by long stability or around a move
      if (link_stable || shift || (phase_last != phase)) begin
        err_count <= '0;
      end else if (phase_err && !vote_to_shift) begin
        err_count <= err_count + 1'b1;  // saturates at all ones
      end

      // --------------------
      // four-state phase machine
      if (shift) begin
        if (move_dn) begin
          phase <= phase_t'(ph_dn);
        end else begin
          phase <= phase_t'(ph_up);
        end
      end
    end
  end

endmodule

//--- edge_align.sv
`timescale 1ns/10ps

module edge_align #(
  parameter bit INVERT = 1'b0  // lane routed with swapped p/n
) (
  input  logic                  fastclock,
  input  logic                  rst_n,
  input  sbit_rx_pkg::os_word_t word_clean,
  input  logic [3:0]            eq4,
  input  sbit_rx_pkg::phase_t   phase,
  input  logic                  ext_pos_edge,  // edge choice from outside
  input  logic                  use_ext_edge,
  output logic                  pos_edge,      // data sits on the rising half
  output logic                  phase_err,
  output logic                  d0,
  output logic                  d1
);
  import sbit_rx_pkg::*;

  logic [1:0] pair_sel;     // {pos sample, neg sample} at the chosen phase
  logic [1:0] pair_q;       // stage 3
  logic       neg_q;        // neg sample of the word before
  logic [1:0] ph_dn;
  logic [1:0] ph_opp;
  logic       err_sel;
  logic       data_on_neg;  // framing bit last seen on the falling half

  assign ph_dn  = phase - 2'd1;
  assign ph_opp = phase + 2'd2;

  assign pair_sel = {word_clean.halves.pos_half[phase], word_clean.halves.neg_half[phase]};

  // an edge next to the sample or facing it from the far side counts as an error
  // only the phase two away from the edge comes out clean
  assign err_sel = eq4[phase] || eq4[ph_dn] || eq4[ph_opp];

  // --------------------
  // stage 3, phase mux
  always_ff @(posedge fastclock) begin
    pair_q <= INVERT ? ~pair_sel : pair_sel;
    if (!rst_n) begin
      phase_err <= 1'b0;
    end else begin
      phase_err <= err_sel;
    end
  end

  // which half carries the framing bit
  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      data_on_neg <= 1'b0;
    end else if (pair_q[1]) begin
      data_on_neg <= 1'b0;
    end else if (pair_q[0]) begin
      data_on_neg <= 1'b1;
    end
  end

  assign pos_edge = use_ext_edge ? ext_pos_edge : !data_on_neg;

  // --------------------
  // stage 4, output bits
  // on the falling half a pair spans the previous neg sample and this pos sample
  always_ff @(posedge fastclock) begin
    neg_q <= pair_q[0];
    if (!rst_n) begin
      d0 <= 1'b0;
      d1 <= 1'b0;
    end else if (pos_edge) begin
      d0 <= pair_q[1];
      d1 <= pair_q[0];
    end else begin
      d0 <= neg_q;
      d1 <= pair_q[1];
    end
  end

endmodule

//--- oversampler.sv
`timescale 1ns/10ps

module oversampler #(
  parameter bit PHASE_SEL_EXTERNAL = 1'b0,  // 1 takes phase and edge from outside
  parameter bit INVERT             = 1'b0
) (
  input  logic                  fastclock,
  input  logic                  rst_n,
  input  sbit_rx_pkg::os_word_t word,
  input  sbit_rx_pkg::phase_t   phase_in,
  input  logic                  pos_edge_in,
  input  logic                  manual,       // internal lane only, force phase_in
  output sbit_rx_pkg::phase_t   phase_out,
  output logic                  pos_edge_out,
  output logic                  locked,
  output logic                  phase_err,
  output logic                  d0,
  output logic                  d1
);
  import sbit_rx_pkg::*;

  os_word_t   word_clean;
  logic [3:0] eq4;
  phase_t     phase_sel;     // phase driving the mux
  logic       use_ext_edge;

  sample_front u_front (
    .fastclock  (fastclock),
    .rst_n      (rst_n),
    .word       (word),
    .word_clean (word_clean),
    .eq4        (eq4)
  );

  if (PHASE_SEL_EXTERNAL) begin : g_ext
    // --------------------
    // follower lane, timing comes from the sot lane
    phase_t phase_in_q;

    always_ff @(posedge fastclock) begin
      if (!rst_n) begin
        phase_in_q <= PHASE_00;
      end else begin
        phase_in_q <= phase_in;
      end
    end

    assign phase_sel    = phase_in_q;
    assign use_ext_edge = 1'b1;
    assign locked       = 1'b0;  // no voter here
  end else begin : g_int
    // --------------------
    // self-aligning lane
    phase_vote u_vote (
      .fastclock    (fastclock),
      .rst_n        (rst_n),
      .eq4          (eq4),
      .phase_err    (phase_err),
      .manual       (manual),
      .manual_phase (phase_in),
      .phase        (phase_sel),
      .locked       (locked)
    );

    assign use_ext_edge = manual;  // edge forced together with the phase
  end

  edge_align #(
    .INVERT (INVERT)
  ) u_align (
    .fastclock    (fastclock),
    .rst_n        (rst_n),
    .word_clean   (word_clean),
    .eq4          (eq4),
    .phase        (phase_sel),
    .ext_pos_edge (pos_edge_in),
    .use_ext_edge (use_ext_edge),
    .pos_edge     (pos_edge_out),
    .phase_err    (phase_err),
    .d0           (d0),
    .d1           (d1)
  );

  assign phase_out = phase_sel;

endmodule

//--- rx_apb_regs.sv
`timescale 1ns/10ps
`include "sbit_rx_settings.svh"

module rx_apb_regs (
  input  logic                           fastclock,
  input  logic                           rst_n,
  input  logic [`SBIT_RX_APB_ADDR_W-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [7:0]                     pwdata,
  output logic [7:0]                     prdata,
  output logic                           pready,
  output logic                           pslverr,
  input  sbit_rx_pkg::phase_t            sot_phase,
  input  logic                           sot_pos_edge,
  input  logic                           sot_locked,
  input  logic                           sot_phase_err,
  output logic                           manual,
  output sbit_rx_pkg::phase_t            lane_phase,     // phase for every lane
  output logic                           lane_pos_edge
);
  import sbit_rx_pkg::*;

  logic [3:0] ctrl_q;         // {manual_pos_edge, manual_phase, manual}
  logic       err_seen;       // sticky sot phase error
  logic       hit_ctrl;
  logic       hit_status;
  logic       access;         // enable cycle of a transfer
  logic       wr_en;
  phase_t     ctrl_phase;
  logic       ctrl_pos_edge;
  logic [7:0] status;

  assign hit_ctrl   = (paddr == `SBIT_RX_ADDR_CTRL);
  assign hit_status = (paddr == `SBIT_RX_ADDR_STATUS);
  assign access     = psel && penable;
  assign wr_en      = access && pwrite;

  // --------------------
  // register writes, committed on the enable edge
  always_ff @(posedge fastclock) begin
    if (!rst_n) begin
      ctrl_q   <= '0;
      err_seen <= 1'b0;
    end else begin
      if (wr_en && hit_ctrl) begin
        ctrl_q <= pwdata[3:0];
      end
      // a new error wins over a clear in the same cycle
      if (sot_phase_err) begin
        err_seen <= 1'b1;
      end else if (wr_en && hit_status && pwdata[`SBIT_RX_STS_ERR_BIT]) begin
        err_seen <= 1'b0;
      end
    end
  end

  assign status = {3'b000, err_seen, sot_locked, sot_pos_edge, sot_phase};

  // --------------------
  // read mux, valid through the whole transfer
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (hit_ctrl) begin
        prdata = {4'b0000, ctrl_q};
      end else if (hit_status) begin
        prdata = status;
      end
    end
  end

  assign pready  = 1'b1;                                // never stalls
  assign pslverr = access && !(hit_ctrl || hit_status);  // unmapped address

  // --------------------
  // lane timing, sot voter or software
  assign manual        = ctrl_q[0];
  assign ctrl_phase    = phase_t'(ctrl_q[2:1]);
  assign ctrl_pos_edge = ctrl_q[3];

  assign lane_phase    = manual ? ctrl_phase : sot_phase;
  assign lane_pos_edge = manual ? ctrl_pos_edge : sot_pos_edge;

endmodule

//--- sbit_rx.sv
`timescale 1ns/10ps
`include "sbit_rx_settings.svh"

module sbit_rx (
  input  logic                           fastclock,
  input  logic                           rst_n,
  input  logic [`SBIT_RX_APB_ADDR_W-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [7:0]                     pwdata,
  output logic [7:0]                     prdata,
  output logic                           pready,
  output logic                           pslverr,
  input  sbit_rx_pkg::os_word_t          sot_word,
  input  sbit_rx_pkg::os_word_t          sbit_word_0,
  input  sbit_rx_pkg::os_word_t          sbit_word_1,
  input  sbit_rx_pkg::os_word_t          sbit_word_2,
  input  sbit_rx_pkg::os_word_t          sbit_word_3,
  output logic                           sot_d0,
  output logic                           sot_d1,
  output logic [`SBIT_RX_NUM_LANES-1:0]  sbit_d0,
  output logic [`SBIT_RX_NUM_LANES-1:0]  sbit_d1
);
  import sbit_rx_pkg::*;

  os_word_t lane_word [`SBIT_RX_NUM_LANES];  // s-bit words as an array
  phase_t   sot_phase;
  phase_t   lane_phase;
  logic     sot_pos_edge;
  logic     sot_locked;
  logic     sot_phase_err;
  logic     manual;
  logic     lane_pos_edge;

  assign lane_word[0] = sbit_word_0;
  assign lane_word[1] = sbit_word_1;
  assign lane_word[2] = sbit_word_2;
  assign lane_word[3] = sbit_word_3;

  rx_apb_regs u_regs (
    .fastclock (fastclock), .rst_n (rst_n),
    .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
    .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .sot_phase (sot_phase), .sot_pos_edge (sot_pos_edge),
    .sot_locked (sot_locked), .sot_phase_err (sot_phase_err),
    .manual (manual), .lane_phase (lane_phase), .lane_pos_edge (lane_pos_edge)
  );

  // --------------------
  // sot lane finds its own phase, forced only in manual mode
  oversampler #(.PHASE_SEL_EXTERNAL (1'b0)) u_sot (
    .fastclock (fastclock), .rst_n (rst_n), .word (sot_word),
    .phase_in (lane_phase), .pos_edge_in (lane_pos_edge), .manual (manual),
    .phase_out (sot_phase), .pos_edge_out (sot_pos_edge),
    .locked (sot_locked), .phase_err (sot_phase_err),
    .d0 (sot_d0), .d1 (sot_d1)
  );

  // --------------------
  // s-bit lanes ride on the sot timing
  for (genvar i = 0; i < `SBIT_RX_NUM_LANES; i++) begin : g_sbit
    oversampler #(.PHASE_SEL_EXTERNAL (1'b1)) u_lane (
      .fastclock (fastclock), .rst_n (rst_n), .word (lane_word[i]),
      .phase_in (lane_phase), .pos_edge_in (lane_pos_edge), .manual (manual),
      .phase_out (), .pos_edge_out (), .locked (), .phase_err (),
      .d0 (sbit_d0[i]), .d1 (sbit_d1[i])
    );
  end

endmodule

//--- sbit_rx_tb.sv
`timescale 1ns/10ps
`include "sbit_rx_settings.svh"

module sbit_rx_tb;
  import sbit_rx_pkg::*;

  localparam int HIST = 16384;      // bit history depth in a power of two
  localparam int MASK = HIST - 1;
  localparam int NL   = `SBIT_RX_NUM_LANES + 1;  // lane 0 is sot

  typedef struct {
    int         skew;       // phase the data edge falls on
    int         half;       // extra half period shift
    logic [7:0] pattern;    // sot pairs with cycle 0 in the top bits
    bit         manual;
    phase_t     mphase;
    bit         mpos;
    phase_t     exp_phase;
    bit         exp_pos;
  } row_t;

  logic fastclock = 1'b0;
  logic rst_n;
  logic [`SBIT_RX_APB_ADDR_W-1:0] paddr;
  logic psel, penable, pwrite;
  logic [7:0] pwdata, prdata;
  logic pready, pslverr;
  os_word_t sot_word, sbit_word_0, sbit_word_1, sbit_word_2, sbit_word_3;
  logic sot_d0, sot_d1;
  logic [`SBIT_RX_NUM_LANES-1:0] sbit_d0, sbit_d1;

  int   errors = 0;
  int   seed = 22;
  int   cyc = 0;         // index of the next driven word
  bit   stim_on = 0;
  int   cur_skew = 0;
  int   cur_half = 0;
  logic [7:0] cur_pattern = 8'h00;
  logic tx_bits [NL][HIST];  // transmitted bits at two per cycle
  logic rec_d0  [NL][HIST];  // dut outputs seen at each falling edge
  logic rec_d1  [NL][HIST];
  row_t rows [7];

  always #2 fastclock = ~fastclock;  // 4 ns period

  sbit_rx dut0 (
    .fastclock (fastclock), .rst_n (rst_n),
    .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
    .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .sot_word (sot_word), .sbit_word_0 (sbit_word_0), .sbit_word_1 (sbit_word_1),
    .sbit_word_2 (sbit_word_2), .sbit_word_3 (sbit_word_3),
    .sot_d0 (sot_d0), .sot_d1 (sot_d1), .sbit_d0 (sbit_d0), .sbit_d1 (sbit_d1)
  );

  // --------------------
  // lane generator
  // sample t of the line holds bit (t - skew - 4*half) / 4
  function automatic logic sample_bit(int lane, int t);
    int m;
    m = (t - cur_skew - 4 * cur_half) >>> 2;
    return tx_bits[lane][m & MASK];
  endfunction

  function automatic logic [7:0] build_word(int lane, int n);
    logic [7:0] w;
    for (int j = 0; j < 8; j++) w[j] = sample_bit(lane, 8 * n + j);
    return w ^ 8'h55;  // even bits come off the inverted leg
  endfunction

  always @(negedge fastclock) begin : drive_lanes
    int k;
    int rnd;
    rec_d0[0][cyc & MASK] = sot_d0;
    rec_d1[0][cyc & MASK] = sot_d1;
    for (int l = 0; l < `SBIT_RX_NUM_LANES; l++) begin
      rec_d0[l+1][cyc & MASK] = sbit_d0[l];
      rec_d1[l+1][cyc & MASK] = sbit_d1[l];
    end
    k = cyc % 4;
    tx_bits[0][(2*cyc) & MASK]   = stim_on & cur_pattern[7-2*k];
    tx_bits[0][(2*cyc+1) & MASK] = stim_on & cur_pattern[6-2*k];
    for (int l = 1; l < NL; l++) begin
      rnd = $random(seed);
      tx_bits[l][(2*cyc) & MASK]   = stim_on & rnd[0];
      tx_bits[l][(2*cyc+1) & MASK] = stim_on & rnd[1];
    end
    sot_word.raw    = build_word(0, cyc);
    sbit_word_0.raw = build_word(1, cyc);
    sbit_word_1.raw = build_word(2, cyc);
    sbit_word_2.raw = build_word(3, cyc);
    sbit_word_3.raw = build_word(4, cyc);
    cyc++;
  end

  // --------------------
  // compare tasks
  task automatic check_phase(string name, phase_t got, phase_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // --------------------
  // apb and reset
  task automatic apb_xfer(input logic [3:0] addr, input logic wr, input logic [7:0] wdata,
                          output logic [7:0] rdata, output logic err);
    @(negedge fastclock);
    paddr = addr;
    pwrite = wr;
    pwdata = wdata;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge fastclock);
    penable = 1'b1;
    #1;               // let the enable cycle settle
    rdata = prdata;
    err = pslverr;
    check_bit("pready", pready, 1'b1);  // zero wait states
    @(negedge fastclock);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reset_dut();
    @(negedge fastclock);
    rst_n = 1'b0;
    repeat (2) @(negedge fastclock);
    rst_n = 1'b1;
  endtask

  task automatic wait_lock();
    logic [7:0] rd;
    logic err;
    bit done;
    done = 0;
    for (int k = 0; k < 667 && !done; k++) begin  // three cycles per read
      apb_xfer(`SBIT_RX_ADDR_STATUS, 1'b0, 8'h00, rd, err);
      done = rd[3];
    end
    if (!done) begin
      errors++;
      $display("SoT lane did not lock within 2000 cycles at %0t", $time);
    end
  endtask

  // searches the output history for a lag that matches every transmitted pair
  task automatic check_aligned(int lane, string name);
    int found;
    bit ok;
    int c;
    found = -1;
    for (int lag = 0; lag < 16 && found < 0; lag++) begin
      ok = 1;
      for (int r = cyc - 34; r < cyc - 1; r++) begin
        c = r - lag;
        if (rec_d0[lane][r & MASK] !== tx_bits[lane][(2*c) & MASK]) ok = 0;
        if (rec_d1[lane][r & MASK] !== tx_bits[lane][(2*c+1) & MASK]) ok = 0;
      end
      if (ok) found = lag;
    end
    if (found < 0) begin
      errors++;
      $display("%s data never lined up with the sent pairs within 16 cycles at %0t",
               name, $time);
    end
  endtask

  // outputs under a forced phase are the generator samples 4 edges later
  task automatic check_forced(int lane, string name, int ph, bit pos);
    int c;
    logic s_pos;
    logic s_neg;
    logic s_prev;
    for (int r = cyc - 30; r < cyc - 1; r++) begin
      c = r - 4;
      s_pos  = sample_bit(lane, 8 * c + ph);
      s_neg  = sample_bit(lane, 8 * c + 4 + ph);
      s_prev = sample_bit(lane, 8 * (c - 1) + 4 + ph);  // neg sample one word back
      check_bit({name, ".d0"}, rec_d0[lane][r & MASK], pos ? s_pos : s_prev);
      check_bit({name, ".d1"}, rec_d1[lane][r & MASK], pos ? s_neg : s_pos);
    end
  endtask

  // --------------------
  // watchdog
  initial begin
    #800000;
    $display("simulation ran past its time limit");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    logic [7:0] rd;
    logic err;
    rst_n = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    sot_word = 8'h55;
    sbit_word_0 = 8'h55;
    sbit_word_1 = 8'h55;
    sbit_word_2 = 8'h55;
    sbit_word_3 = 8'h55;

    //        skew half pattern man  mphase    mpos exp_phase exp_pos
    rows[0] = '{0, 0, 8'hA2, 0, PHASE_00, 0, PHASE_10, 1};
    rows[1] = '{1, 0, 8'hA2, 0, PHASE_00, 0, PHASE_11, 1};
    rows[2] = '{2, 0, 8'hA2, 0, PHASE_00, 0, PHASE_00, 0};
    rows[3] = '{3, 0, 8'hA2, 0, PHASE_00, 0, PHASE_01, 0};
    rows[4] = '{1, 1, 8'hA2, 0, PHASE_00, 0, PHASE_11, 0};  // half period late
    rows[5] = '{0, 0, 8'hA2, 1, PHASE_10, 1, PHASE_10, 1};
    rows[6] = '{1, 0, 8'hA2, 1, PHASE_00, 0, PHASE_00, 0};

    // --------------------
    // reset values
    reset_dut();
    check_bit("sot_d0", sot_d0, 1'b0);
    check_bit("sot_d1", sot_d1, 1'b0);
    check_word("sbit_d0", {4'h0, sbit_d0}, 8'h00);
    check_word("sbit_d1", {4'h0, sbit_d1}, 8'h00);
    apb_xfer(`SBIT_RX_ADDR_STATUS, 1'b0, 8'h00, rd, err);
    check_word("status", rd, 8'h04);  // phase 0, pos edge, unlocked
    apb_xfer(`SBIT_RX_ADDR_CTRL, 1'b0, 8'h00, rd, err);
    check_word("ctrl", rd, 8'h00);

    // register access
    apb_xfer(`SBIT_RX_ADDR_CTRL, 1'b1, 8'h0B, rd, err);
    check_bit("pslverr", err, 1'b0);
    apb_xfer(`SBIT_RX_ADDR_CTRL, 1'b0, 8'h00, rd, err);
    check_word("ctrl", rd, 8'h0B);
    apb_xfer(`SBIT_RX_ADDR_CTRL, 1'b1, 8'h00, rd, err);
    apb_xfer(4'h8, 1'b0, 8'h00, rd, err);
    check_bit("pslverr", err, 1'b1);

    // --------------------
    // table loop
    foreach (rows[i]) begin
      cur_skew = rows[i].skew;
      cur_half = rows[i].half;
      cur_pattern = rows[i].pattern;
      stim_on = 1;
      reset_dut();
      if (rows[i].manual) begin
        apb_xfer(`SBIT_RX_ADDR_CTRL, 1'b1,
                 {4'h0, rows[i].mpos, rows[i].mphase, 1'b1}, rd, err);
        repeat (8) @(negedge fastclock);
      end else begin
        wait_lock();
      end
      apb_xfer(`SBIT_RX_ADDR_STATUS, 1'b0, 8'h00, rd, err);
      check_phase("status.phase", phase_t'(rd[1:0]), rows[i].exp_phase);
      check_bit("status.sel_pos_edge", rd[2], rows[i].exp_pos);
      check_bit("status.locked", rd[3], !rows[i].manual);
      if (i == 0) begin  // lock took phase moves, so an error was seen
        check_bit("status.err_seen", rd[4], 1'b1);
        apb_xfer(`SBIT_RX_ADDR_STATUS, 1'b1, 8'h10, rd, err);
        apb_xfer(`SBIT_RX_ADDR_STATUS, 1'b0, 8'h00, rd, err);
        check_bit("status.err_seen", rd[4], 1'b0);
      end
      repeat (40) @(negedge fastclock);
      for (int l = 0; l < NL; l++) begin
        if (rows[i].manual) begin
          check_forced(l, $sformatf("lane%0d", l), rows[i].mphase, rows[i].mpos);
        end else begin
          check_aligned(l, $sformatf("lane%0d", l));
        end
      end
    end

    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- sbit_rx.f
+incdir+.
sbit_rx_pkg.sv
sample_front.sv
phase_vote.sv
edge_align.sv
oversampler.sv
rx_apb_regs.sv
sbit_rx.sv
sbit_rx_tb.sv

//--- run_sbit_rx.sh
#!/bin/sh
# build and run the sbit_rx testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module sbit_rx_tb -f sbit_rx.f -o sbit_rx_sim \
  && ./obj_dir/sbit_rx_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "\*\*\* FAILED \*\*\*" sim.log && exit 1
grep -q "\*\*\* PASSED \*\*\*" sim.log || exit 1
exit 0
